// ==== common/pwm_pkg.sv ====
// Shared widths, vector types, register offsets and FSM/counter enums for the PWM chain
package pwm_pkg;

    // Bus and setting widths
    localparam int bus_width = 32;
    localparam int deadtime_width = 16;
    localparam int shift_width = 16;

    // Fixed by the register map
    localparam int channel_count = 3;

    typedef logic [bus_width-1:0] bus_addr_t;
    typedef logic [bus_width-1:0] bus_data_t;
    typedef logic [deadtime_width-1:0] deadtime_t;
    typedef logic [shift_width-1:0] shift_t;

    // Timebase counting modes where codes 3 to 7 behave as up counting
    typedef enum logic [2:0] {
        mode_up = 3'd0,
        mode_down = 3'd1,
        mode_up_down = 3'd2
    } counter_mode_t;

    // Register block write handling
    typedef enum logic {
        idle_state,
        act_state
    } bus_state_t;

    // Comparator thresholds
    localparam bus_addr_t reg_cmp_low0 = 32'h00;
    localparam bus_addr_t reg_cmp_low1 = 32'h04;
    localparam bus_addr_t reg_cmp_low2 = 32'h08;
    localparam bus_addr_t reg_cmp_high0 = 32'h0C;
    localparam bus_addr_t reg_cmp_high1 = 32'h10;
    localparam bus_addr_t reg_cmp_high2 = 32'h14;

    // Dead times are locked while the counter runs
    localparam bus_addr_t reg_deadtime0 = 32'h18;
    localparam bus_addr_t reg_deadtime1 = 32'h1C;
    localparam bus_addr_t reg_deadtime2 = 32'h20;

    // Timebase setup
    localparam bus_addr_t reg_counter_start = 32'h24;
    localparam bus_addr_t reg_counter_stop = 32'h28;
    localparam bus_addr_t reg_timebase_shift = 32'h2C;

    // Enables and control
    localparam bus_addr_t reg_output_enable = 32'h30;
    localparam bus_addr_t reg_deadtime_enable = 32'h34;
    localparam bus_addr_t reg_counter_control = 32'h38;

endpackage

// ==== pwm_chain/chain_control_unit.sv ====
// Bus write handler and settings register file of the PWM chain
`timescale 1ns/1ns

module chain_control_unit #(
    parameter pwm_pkg::bus_addr_t BASE_ADDRESS = '0,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic write_strobe,
    input  pwm_pkg::bus_addr_t address,
    input  pwm_pkg::bus_data_t write_data,
    input  logic counter_running,
    output logic ready,
    output logic counter_run,
    output pwm_pkg::counter_mode_t counter_mode,
    output logic [COUNTER_WIDTH-1:0] counter_start,
    output logic [COUNTER_WIDTH-1:0] counter_stop,
    output pwm_pkg::shift_t timebase_shift,
    output logic [pwm_pkg::channel_count-1:0][COUNTER_WIDTH-1:0] threshold_low,
    output logic [pwm_pkg::channel_count-1:0][COUNTER_WIDTH-1:0] threshold_high,
    output pwm_pkg::deadtime_t [pwm_pkg::channel_count-1:0] deadtime,
    output logic [pwm_pkg::channel_count-1:0] deadtime_enable,
    output logic [2*pwm_pkg::channel_count-1:0] output_enable
);
    import pwm_pkg::*;

    bus_state_t state;
    logic act_done;
    logic dc_mode;

    // Write captured at the accepting edge
    bus_addr_t latched_address;
    bus_data_t latched_data;

    logic [COUNTER_WIDTH-1:0] latched_value;

    assign latched_value = latched_data[COUNTER_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (state == idle_state && write_strobe) begin
            latched_address <= address;
            latched_data <= write_data;
        end

        if (!reset) begin
            state <= idle_state;
            act_done <= 1'b0;
            ready <= 1'b1;
            dc_mode <= 1'b0;
            counter_run <= 1'b0;
            counter_mode <= mode_up;
            counter_start <= '0;
            counter_stop <= '0;
            timebase_shift <= '0;
            threshold_low <= '0;
            threshold_high <= '1;
            deadtime <= '0;
            deadtime_enable <= '0;
            output_enable <= '0;
        end else begin
            case (state)
                idle_state: begin
                    act_done <= 1'b0;
                    if (write_strobe) begin
                        ready <= 1'b0;
                        state <= act_state;
                    end
                end
                act_state: begin
                    if (act_done) begin
                        // Second cycle releases the bus
                        ready <= 1'b1;
                        state <= idle_state;
                    end else begin
                        act_done <= 1'b1;
                        case (latched_address)
                            BASE_ADDRESS + reg_cmp_low0: threshold_low[0] <= latched_value;
                            BASE_ADDRESS + reg_cmp_low1: threshold_low[1] <= latched_value;
                            BASE_ADDRESS + reg_cmp_low2: threshold_low[2] <= latched_value;
                            BASE_ADDRESS + reg_cmp_high0: threshold_high[0] <= latched_value;
                            BASE_ADDRESS + reg_cmp_high1: threshold_high[1] <= latched_value;
                            BASE_ADDRESS + reg_cmp_high2: threshold_high[2] <= latched_value;
                            BASE_ADDRESS + reg_deadtime0: begin
                                if (!counter_running) begin
                                    deadtime[0] <= latched_data[deadtime_width-1:0];
                                end
                            end
                            BASE_ADDRESS + reg_deadtime1: begin
                                if (!counter_running) begin
                                    deadtime[1] <= latched_data[deadtime_width-1:0];
                                end
                            end
                            BASE_ADDRESS + reg_deadtime2: begin
                                if (!counter_running) begin
                                    deadtime[2] <= latched_data[deadtime_width-1:0];
                                end
                            end
                            BASE_ADDRESS + reg_counter_start: begin
                                if (!counter_running) begin
                                    counter_start <= latched_value;
                                    // In DC mode the bottom limit doubles as all low thresholds
                                    if (dc_mode) begin
                                        threshold_low <= {channel_count{latched_value}};
                                    end
                                end
                            end
                            BASE_ADDRESS + reg_counter_stop: begin
                                if (!counter_running) begin
                                    counter_stop <= latched_value;
                                    if (dc_mode) begin
                                        threshold_high <= {channel_count{latched_value}};
                                    end
                                end
                            end
                            BASE_ADDRESS + reg_timebase_shift: begin
                                if (!counter_running) begin
                                    timebase_shift <= latched_data[shift_width-1:0];
                                end
                            end
                            BASE_ADDRESS + reg_output_enable: begin
                                output_enable <= latched_data[2*channel_count-1:0];
                            end
                            BASE_ADDRESS + reg_deadtime_enable: begin
                                deadtime_enable <= latched_data[channel_count-1:0];
                            end
                            BASE_ADDRESS + reg_counter_control: begin
                                counter_run <= latched_data[4];
                                if (!counter_running) begin
                                    dc_mode <= latched_data[3];
                                    if (latched_data[3]) begin
                                        counter_mode <= mode_up_down;
                                    end else begin
                                        case (latched_data[2:0])
                                            3'd1: counter_mode <= mode_down;
                                            3'd2: counter_mode <= mode_up_down;
                                            default: counter_mode <= mode_up;
                                        endcase
                                    end
                                end
                            end
                            // Unmapped address leaves every register unchanged
                            default: ;
                        endcase
                    end
                end
                default: state <= idle_state;
            endcase
        end
    end

endmodule

// ==== pwm_chain/pwm_comparator_bank.sv ====
// Registered window comparators, one raw PWM signal per channel
`timescale 1ns/1ns

module pwm_comparator_bank #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic [COUNTER_WIDTH-1:0] counter_value,
    input  logic [pwm_pkg::channel_count-1:0][COUNTER_WIDTH-1:0] threshold_low,
    input  logic [pwm_pkg::channel_count-1:0][COUNTER_WIDTH-1:0] threshold_high,
    output logic [pwm_pkg::channel_count-1:0] pwm_raw
);
    import pwm_pkg::*;

    logic [channel_count-1:0] above_low;
    logic [channel_count-1:0] below_high;

    // Window edges per channel
    always_comb begin
        for (int ch = 0; ch < channel_count; ch++) begin
            above_low[ch] = counter_value >= threshold_low[ch];
            below_high[ch] = counter_value < threshold_high[ch];
        end
    end

    // High inside [low, high) one cycle behind the count
    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_raw <= '0;
        end else begin
            pwm_raw <= above_low & below_high;
        end
    end

endmodule

// ==== pwm_chain/pwm_deadtime.sv ====
// Complementary pair with rising edge dead time and output enables
`timescale 1ns/1ns

module pwm_deadtime (
    input  logic clock,
    input  logic reset,
    input  logic pwm_raw_in,
    input  pwm_pkg::deadtime_t deadtime,
    input  logic deadtime_enable,
    input  logic [1:0] output_enable,
    output logic pwm_high,
    output logic pwm_low
);
    import pwm_pkg::*;

    // Index 0 is the high side, index 1 the low side
    logic [1:0] side_target;
    logic [1:0] side_out;
    deadtime_t hold_count [2];

    assign side_target = {~pwm_raw_in, pwm_raw_in};

    always_ff @(posedge clock) begin
        if (!reset) begin
            side_out <= '0;
            hold_count[0] <= '0;
            hold_count[1] <= '0;
        end else begin
            for (int side = 0; side < 2; side++) begin
                if (!side_target[side]) begin
                    // Falling edge passes straight through and rearms the hold-off
                    side_out[side] <= 1'b0;
                    hold_count[side] <= deadtime;
                end else if (!deadtime_enable || hold_count[side] == '0) begin
                    side_out[side] <= 1'b1;
                end else begin
                    hold_count[side] <= hold_count[side] - 1'b1;
                end
            end
        end
    end

    // Per-side masking
    assign pwm_high = side_out[0] & output_enable[0];
    assign pwm_low = side_out[1] & output_enable[1];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the PWM chain testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module pwm_chain_tb -f verilog.f -o pwm_chain_sim \
    && ./obj_dir/pwm_chain_sim | tee sim.log \
    && grep -q "PASS: all tests" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sim/pwm_chain_tb.sv ====
// Testbench top with bus write tasks, cycle reference model, compare process and tests
`timescale 1ns/1ns

module pwm_chain_tb;
    import pwm_pkg::*;

    localparam bus_addr_t base_address = 32'h0;
    localparam int counter_width = 16;
    localparam int wait_limit = 40;

    logic clock;
    logic reset;
    logic write_strobe;
    bus_addr_t address;
    bus_data_t write_data;
    logic ready;
    logic [5:0] pwm_out;
    logic [counter_width-1:0] counter_value;
    logic counter_running;

    string test_name = "reset";
    int limit_low;
    int limit_high;
    int span;

    // Reference model state at its reset values
    logic m_busy = 1'b0;
    logic m_act_done = 1'b0;
    logic m_ready = 1'b1;
    logic m_dc = 1'b0;
    logic m_run = 1'b0;
    counter_mode_t m_mode = mode_up;
    logic [counter_width-1:0] m_start = '0;
    logic [counter_width-1:0] m_stop = '0;
    shift_t m_shift = '0;
    logic [2:0][counter_width-1:0] m_low = '0;
    logic [2:0][counter_width-1:0] m_high = '1;
    logic [2:0][deadtime_width-1:0] m_dt = '0;
    logic [2:0] m_dte = '0;
    logic [5:0] m_oe = '0;
    bus_addr_t m_addr = '0;
    bus_data_t m_data = '0;
    logic [counter_width-1:0] m_count = '0;
    logic m_running = 1'b0;
    logic m_down = 1'b0;
    logic [2:0] m_raw = '0;
    logic [5:0] m_side = '0;
    logic [5:0][deadtime_width-1:0] m_hold = '0;

    tb_clock_gen i_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    pwm_chain_top #(
        .BASE_ADDRESS(base_address),
        .COUNTER_WIDTH(counter_width)
    ) i_dut (
        .clock(clock),
        .reset(reset),
        .write_strobe(write_strobe),
        .address(address),
        .write_data(write_data),
        .ready(ready),
        .pwm_out(pwm_out),
        .counter_value(counter_value),
        .counter_running(counter_running)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Mismatch in test %s: %s expected 0x%0h actual 0x%0h",
                                test_name, what, expected, actual));
    endtask

    // Register map decode of one accepted write
    function automatic void apply_write(input logic locked);
        bus_addr_t offset;
        logic [1:0] slot;
        logic [counter_width-1:0] value;
        offset = m_addr - base_address;
        // Threshold and dead time groups span 12 bytes each
        slot = 2'((offset % 12) >> 2);
        value = m_data[counter_width-1:0];
        case (offset)
            reg_cmp_low0, reg_cmp_low1, reg_cmp_low2: m_low[slot] = value;
            reg_cmp_high0, reg_cmp_high1, reg_cmp_high2: m_high[slot] = value;
            reg_deadtime0, reg_deadtime1, reg_deadtime2: begin
                if (!locked)
                    m_dt[slot] = m_data[deadtime_width-1:0];
            end
            reg_counter_start: begin
                if (!locked) begin
                    m_start = value;
                    if (m_dc)
                        m_low = {3{value}};
                end
            end
            reg_counter_stop: begin
                if (!locked) begin
                    m_stop = value;
                    if (m_dc)
                        m_high = {3{value}};
                end
            end
            reg_timebase_shift: begin
                if (!locked)
                    m_shift = m_data[shift_width-1:0];
            end
            reg_output_enable: m_oe = m_data[5:0];
            reg_deadtime_enable: m_dte = m_data[2:0];
            reg_counter_control: begin
                m_run = m_data[4];
                if (!locked) begin
                    m_dc = m_data[3];
                    if (m_data[3] || m_data[2:0] == 3'd2)
                        m_mode = mode_up_down;
                    else if (m_data[2:0] == 3'd1)
                        m_mode = mode_down;
                    else
                        m_mode = mode_up;
                end
            end
            default: ;
        endcase
    endfunction

    function automatic void step_counter();
        if (!m_run) begin
            m_count = '0;
            m_running = 1'b0;
            m_down = 1'b0;
        end else if (!m_running) begin
            // Start load includes the phase shift
            m_running = 1'b1;
            m_down = 1'b0;
            m_count = (m_mode == mode_down) ? m_stop + m_shift : m_start + m_shift;
        end else if (m_mode == mode_down) begin
            m_count = (m_count <= m_start) ? m_stop : m_count - 1'b1;
        end else if (m_mode == mode_up_down) begin
            if (m_down ? m_count <= m_start : m_count >= m_stop)
                m_down = !m_down;
            m_count = m_down ? m_count - 1'b1 : m_count + 1'b1;
        end else begin
            m_count = (m_count >= m_stop) ? m_start : m_count + 1'b1;
        end
    endfunction

    // One clock edge of the chain where every stage sees last cycle's values
    function automatic void step_model(input logic strobe, input bus_addr_t addr,
                                       input bus_data_t data);
        logic was_running;
        logic target;
        was_running = m_running;
        // Even index high side, odd index low side
        for (int i = 0; i < 6; i++) begin
            target = (i % 2 == 0) ? m_raw[i / 2] : !m_raw[i / 2];
            if (!target) begin
                m_side[i] = 1'b0;
                m_hold[i] = m_dt[i / 2];
            end else if (!m_dte[i / 2] || m_hold[i] == '0) begin
                m_side[i] = 1'b1;
            end else begin
                m_hold[i] = m_hold[i] - 1'b1;
            end
        end
        for (int i = 0; i < 3; i++) begin
            m_raw[i] = m_count >= m_low[i] && m_count < m_high[i];
        end
        step_counter();
        if (!m_busy) begin
            m_act_done = 1'b0;
            if (strobe) begin
                m_addr = addr;
                m_data = data;
                m_busy = 1'b1;
                m_ready = 1'b0;
            end
        end else if (m_act_done) begin
            m_busy = 1'b0;
            m_ready = 1'b1;
        end else begin
            m_act_done = 1'b1;
            apply_write(was_running);
        end
    endfunction

    // Outputs compared once they have settled after the edge
    always @(posedge clock) begin
        if (reset === 1'b1)
            step_model(write_strobe, address, write_data);
        #1;
        check_value("ready", 32'(m_ready), 32'(ready));
        check_value("counter_running", 32'(m_running), 32'(counter_running));
        check_value("counter_value", 32'(m_count), 32'(counter_value));
        check_value("pwm_out", 32'(m_side & m_oe), 32'(pwm_out));
    end

    task automatic bus_write(input bus_addr_t offset, input bus_data_t data);
        int cycles;
        write_strobe = 1'b1;
        address = base_address + offset;
        write_data = data;
        @(posedge clock);
        #2;
        write_strobe = 1'b0;
        cycles = 0;
        while (ready !== 1'b1) begin
            @(posedge clock);
            #2;
            cycles++;
            if (cycles > wait_limit)
                abort_run("Timeout: ready did not return high after a write");
        end
        check_value("cycles with ready low", 32'd2, 32'(cycles));
    endtask

    task automatic wait_running(input logic level);
        int cycles;
        cycles = 0;
        while (counter_running !== level) begin
            @(posedge clock);
            #2;
            cycles++;
            if (cycles > wait_limit)
                abort_run("Timeout: counter_running did not follow the run bit");
        end
    endtask

    task automatic run_cycles(input int count);
        repeat (count) @(posedge clock);
        #2;
    endtask

    task automatic stop_counter();
        bus_write(reg_counter_control, 32'h0);
        wait_running(1'b0);
    endtask

    // Random window per channel inside the counter range
    task automatic program_windows();
        int low;
        for (int ch = 0; ch < 3; ch++) begin
            low = limit_low + int'($urandom_range(span / 2, 0));
            bus_write(reg_cmp_low0 + 32'(4 * ch), 32'(low));
            bus_write(reg_cmp_high0 + 32'(4 * ch), 32'(low + 1 + int'($urandom_range(span, 0))));
        end
    endtask

    initial begin
        int cycles;
        write_strobe = 1'b0;
        address = '0;
        write_data = '0;
        void'($urandom(92148));
        cycles = 0;
        while (reset !== 1'b1) begin
            @(posedge clock);
            #2;
            cycles++;
            if (cycles > wait_limit)
                abort_run("Timeout: reset was never released");
        end
        @(posedge clock);
        #2;
        test_name = "reset state";
        check_value("pwm_out after reset", 32'd0, 32'(pwm_out));
        check_value("counter_running after reset", 32'd0, 32'(counter_running));
        check_value("ready after reset", 32'd1, 32'(ready));
        test_name = "write handshake";
        bus_write(reg_output_enable, 32'h3F);
        bus_write(32'h100, 32'hFFFF_FFFF);

        test_name = "up mode";
        limit_low = int'($urandom_range(20, 0));
        span = int'($urandom_range(40, 8));
        limit_high = limit_low + span;
        bus_write(reg_counter_start, 32'(limit_low));
        bus_write(reg_counter_stop, 32'(limit_high));
        program_windows();
        bus_write(reg_counter_control, 32'h10);
        wait_running(1'b1);
        run_cycles(2 * (span + 1));
        stop_counter();

        test_name = "down mode";
        bus_write(reg_timebase_shift, 32'd3);
        bus_write(reg_counter_control, 32'h11);
        wait_running(1'b1);
        run_cycles(2 * span + 8);
        stop_counter();
        test_name = "up-down mode";
        bus_write(reg_timebase_shift, 32'd5);
        bus_write(reg_counter_control, 32'h12);
        wait_running(1'b1);
        run_cycles(4 * span + 8);
        stop_counter();

        test_name = "writes while running";
        bus_write(reg_counter_control, 32'h10);
        wait_running(1'b1);
        bus_write(reg_counter_start, 32'(limit_low + 2));
        bus_write(reg_counter_stop, 32'(limit_high + 7));
        bus_write(reg_timebase_shift, 32'd9);
        bus_write(reg_deadtime_enable, 32'h1);
        bus_write(reg_deadtime0, 32'd4);
        bus_write(reg_counter_control, 32'h11);
        run_cycles(span);
        bus_write(reg_cmp_low1, 32'(limit_low + 1));
        bus_write(reg_output_enable, 32'h2D);
        run_cycles(span + 4);
        stop_counter();

        test_name = "dead time";
        for (int ch = 0; ch < 3; ch++) begin
            bus_write(reg_deadtime0 + 32'(4 * ch), 32'($urandom_range(6, 1)));
        end
        bus_write(reg_output_enable, 32'h3F);
        bus_write(reg_deadtime_enable, 32'h7);
        bus_write(reg_counter_control, 32'h10);
        wait_running(1'b1);
        run_cycles(2 * span + 4);
        bus_write(reg_output_enable, 32'h19);
        run_cycles(span + 4);
        stop_counter();

        test_name = "dc mode";
        bus_write(reg_counter_control, 32'h08);
        bus_write(reg_counter_start, 32'(limit_low + 1));
        bus_write(reg_counter_stop, 32'(limit_high - 2));
        bus_write(reg_counter_control, 32'h18);
        wait_running(1'b1);
        run_cycles(4 * span);
        stop_counter();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
// Testbench clock source and active low reset generator
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int half_period = 20,
    parameter int reset_cycles = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // Release happens on a falling edge away from the sampling points
    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end

endmodule

// ==== verilog.f ====
common/pwm_pkg.sv
pwm_chain/chain_control_unit.sv
pwm_chain/pwm_comparator_bank.sv
pwm_chain/pwm_deadtime.sv
verilog/pwm_timebase.sv
verilog/pwm_chain_top.sv
sim/tb_clock_gen.sv
sim/pwm_chain_tb.sv

// ==== verilog/pwm_chain_top.sv ====
// Top level with register block, timebase, comparator bank and three dead time stages
`timescale 1ns/1ns

module pwm_chain_top #(
    parameter pwm_pkg::bus_addr_t BASE_ADDRESS = '0,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic write_strobe,
    input  pwm_pkg::bus_addr_t address,
    input  pwm_pkg::bus_data_t write_data,
    output logic ready,
    output logic [2*pwm_pkg::channel_count-1:0] pwm_out,
    output logic [COUNTER_WIDTH-1:0] counter_value,
    output logic counter_running
);
    import pwm_pkg::*;

    // Settings from the register block
    logic counter_run;
    counter_mode_t counter_mode;
    logic [COUNTER_WIDTH-1:0] counter_start;
    logic [COUNTER_WIDTH-1:0] counter_stop;
    shift_t timebase_shift;
    logic [channel_count-1:0][COUNTER_WIDTH-1:0] threshold_low;
    logic [channel_count-1:0][COUNTER_WIDTH-1:0] threshold_high;
    deadtime_t [channel_count-1:0] deadtime;
    logic [channel_count-1:0] deadtime_enable;
    logic [2*channel_count-1:0] output_enable;

    logic [channel_count-1:0] pwm_raw;

    chain_control_unit #(
        .BASE_ADDRESS(BASE_ADDRESS),
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) i_control (
        .clock(clock),
        .reset(reset),
        .write_strobe(write_strobe),
        .address(address),
        .write_data(write_data),
        .counter_running(counter_running),
        .ready(ready),
        .counter_run(counter_run),
        .counter_mode(counter_mode),
        .counter_start(counter_start),
        .counter_stop(counter_stop),
        .timebase_shift(timebase_shift),
        .threshold_low(threshold_low),
        .threshold_high(threshold_high),
        .deadtime(deadtime),
        .deadtime_enable(deadtime_enable),
        .output_enable(output_enable)
    );

    pwm_timebase #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) i_timebase (
        .clock(clock),
        .reset(reset),
        .counter_run(counter_run),
        .counter_mode(counter_mode),
        .counter_start(counter_start),
        .counter_stop(counter_stop),
        .timebase_shift(timebase_shift),
        .counter_value(counter_value),
        .counter_running(counter_running)
    );

    pwm_comparator_bank #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) i_comparators (
        .clock(clock),
        .reset(reset),
        .counter_value(counter_value),
        .threshold_low(threshold_low),
        .threshold_high(threshold_high),
        .pwm_raw(pwm_raw)
    );

    // Even bit high side, odd bit low side
    for (genvar ch = 0; ch < channel_count; ch++) begin : g_deadtime
        pwm_deadtime i_deadtime (
            .clock(clock),
            .reset(reset),
            .pwm_raw_in(pwm_raw[ch]),
            .deadtime(deadtime[ch]),
            .deadtime_enable(deadtime_enable[ch]),
            .output_enable(output_enable[2*ch+1 -: 2]),
            .pwm_high(pwm_out[2*ch]),
            .pwm_low(pwm_out[2*ch+1])
        );
    end

endmodule

// ==== verilog/pwm_timebase.sv ====
// Up, down and up-down counter between start and stop with phase shift
`timescale 1ns/1ns

module pwm_timebase #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic counter_run,
    input  pwm_pkg::counter_mode_t counter_mode,
    input  logic [COUNTER_WIDTH-1:0] counter_start,
    input  logic [COUNTER_WIDTH-1:0] counter_stop,
    input  pwm_pkg::shift_t timebase_shift,
    output logic [COUNTER_WIDTH-1:0] counter_value,
    output logic counter_running
);
    import pwm_pkg::*;

    logic count_down;
    logic [COUNTER_WIDTH-1:0] shifted_start;
    logic [COUNTER_WIDTH-1:0] shifted_stop;

    // Load values wrap to the counter width
    assign shifted_start = counter_start + COUNTER_WIDTH'(timebase_shift);
    assign shifted_stop = counter_stop + COUNTER_WIDTH'(timebase_shift);

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter_value <= '0;
            counter_running <= 1'b0;
            count_down <= 1'b0;
        end else if (!counter_run) begin
            counter_value <= '0;
            counter_running <= 1'b0;
            count_down <= 1'b0;
        end else if (!counter_running) begin
            // First run cycle
            counter_running <= 1'b1;
            count_down <= 1'b0;
            if (counter_mode == mode_down) begin
                counter_value <= shifted_stop;
            end else begin
                counter_value <= shifted_start;
            end
        end else begin
            case (counter_mode)
                mode_down: begin
                    if (counter_value <= counter_start) begin
                        counter_value <= counter_stop;
                    end else begin
                        counter_value <= counter_value - 1'b1;
                    end
                end
                mode_up_down: begin
                    // Turn around at either limit
                    if (!count_down && counter_value >= counter_stop) begin
                        count_down <= 1'b1;
                        counter_value <= counter_value - 1'b1;
                    end else if (count_down && counter_value <= counter_start) begin
                        count_down <= 1'b0;
                        counter_value <= counter_value + 1'b1;
                    end else if (count_down) begin
                        counter_value <= counter_value - 1'b1;
                    end else begin
                        counter_value <= counter_value + 1'b1;
                    end
                end
                default: begin
                    if (counter_value >= counter_stop) begin
                        counter_value <= counter_start;
                    end else begin
                        counter_value <= counter_value + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule
